/* src.f */
+incdir+verif
rtl/game_pkg.sv
rtl/game_ctrl.sv
rtl/box_raster.sv
rtl/plot_fifo.sv
rtl/plot_clip.sv
rtl/shooter_top.sv
verif/tb_shooter.sv

/* run.sh */
#!/bin/sh
# build and run with Verilator, verdict from the log
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module tb_shooter -o sim_shooter \
  && ./obj_dir/sim_shooter > sim.log 2>&1 \
  || echo "build or simulation error" >> sim.log
cat sim.log
grep -qx "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* verif/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// expected pixel entry {tag, x, y, colour}
// tag 1 marks the first ship draw pixel, tag 2 the last pixel of a clear screen
logic [19:0] exp_q[$];
int          m_ship_x, m_ship_y, m_en_x, m_en_y, m_bul_x, m_bul_y;
bit          m_bul_act;
logic [6:0]  m_lfsr;
game_state_t mstate;
bit          game_done;  // end screen queued
int          frames;

function automatic bit boxes_overlap(int ax, int ay, int aw, int ah,
                                     int bx, int by, int bw, int bh);
  return (ax < bx + bw) && (bx < ax + aw) && (ay < by + bh) && (by < ay + ah);
endfunction

task automatic lfsr_step();
  m_lfsr = {m_lfsr[5:0], m_lfsr[4] ^ m_lfsr[1]};  // taps 4 and 1
endtask

task automatic push_box(int x, int y, int w, int h, color_t c, logic [1:0] tag);
  int  px;
  int  py;
  bit  first;
  first = 1'b1;
  for (int r = 0; r < h; r++)
    for (int k = 0; k < w; k++)
    begin
      px = (x + k) % 256;  // coordinates wrap in their widths
      py = (y + r) % 128;
      if (px < 160 && py < 120)  // clipper removes the rest
      begin
        exp_q.push_back({first ? tag : 2'd0, 8'(px), 7'(py), c});
        first = 1'b0;
      end
    end
endtask

task automatic push_screen(color_t c);
  push_box(0, 0, 160, 119, c, 2'd0);
  push_box(0, 119, 159, 1, c, 2'd0);
  exp_q.push_back({2'd2, 8'd159, 7'd119, c});  // last pixel tagged
endtask

task automatic clear_frame();
  m_ship_x  = 0;
  m_ship_y  = 0;
  m_en_x    = 140;
  m_en_y    = (m_lfsr <= 110) ? int'(m_lfsr) : int'(m_lfsr) - 32;
  m_bul_act = 1'b0;
  push_screen(COL_BLACK);
  mstate    = PLAY;
endtask

task automatic play_frame(bit bl, bit br, bit bu, bit bd, bit f);
  bit lose;
  bit win;
  frames++;
  push_box(m_ship_x, m_ship_y, 16, 10, COL_BLACK, 2'd0);  // erase old
  push_box(m_en_x, m_en_y, 16, 10, COL_BLACK, 2'd0);
  if (m_bul_act)
    push_box(m_bul_x, m_bul_y, 4, 1, COL_BLACK, 2'd0);
  if (bl && m_ship_x != 0) m_ship_x--;
  if (br && m_ship_x < 144) m_ship_x++;
  if (bu && m_ship_y < 110) m_ship_y++;  // up grows y
  if (bd && m_ship_y != 0) m_ship_y--;
  m_en_x--;
  if (m_bul_act)
  begin
    m_bul_x = (m_bul_x + 1) % 256;
    if (m_bul_x >= 156) m_bul_act = 1'b0;
  end
  if (f && !m_bul_act)
  begin
    m_bul_x   = m_ship_x + 16;
    m_bul_y   = m_ship_y + 4;
    m_bul_act = 1'b1;
  end
  lose = boxes_overlap(m_ship_x, m_ship_y, 16, 10, m_en_x, m_en_y, 16, 10) || m_en_x == 0;
  win  = m_bul_act && boxes_overlap(m_bul_x, m_bul_y, 4, 1, m_en_x, m_en_y, 16, 10);
  if (lose || win)
  begin
    mstate    = lose ? GAME_OVER : WIN;
    push_screen(lose ? COL_LOSE : COL_WIN);
    game_done = 1'b1;
  end
  else
  begin
    push_box(m_ship_x, m_ship_y, 16, 10, COL_SHIP, 2'd1);
    push_box(m_en_x, m_en_y, 16, 10, COL_ENEMY, 2'd0);
    if (m_bul_act)
      push_box(m_bul_x, m_bul_y, 4, 1, COL_BULLET, 2'd0);
  end
endtask

`endif

/* verif/tb_shooter.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_shooter import game_pkg::*; ;

  localparam int TICK_DIV   = 64;
  localparam int ROUNDS     = 3;
  localparam int MAX_PIX    = 2 * 19200 + 141 * 648;  // two screens plus every frame
  localparam int MAX_TICKS  = 200;                    // frames plus start wait
  localparam int LIMIT      = ROUNDS * (MAX_PIX * 4 + MAX_TICKS * TICK_DIV) + 64;

  logic        CLOCK_50, rst_n;
  logic        btn_left, btn_right, btn_up, btn_down, fire, restart, plot_ready;
  logic        plot_valid;
  x_t          plot_x;
  y_t          plot_y;
  color_t      plot_color;
  game_state_t game_state;
  int          tcnt, cycles, errors, round_no;
  logic [19:0] head;

  `include "tb_model.svh"

  shooter_top #(.TICK_DIV(TICK_DIV), .FIFO_DEPTH(16)) u_dut (
    .CLOCK_50 (CLOCK_50), .rst_n (rst_n), .btn_left (btn_left), .btn_right (btn_right),
    .btn_up (btn_up), .btn_down (btn_down), .fire (fire), .restart (restart),
    .plot_ready (plot_ready), .plot_valid (plot_valid), .plot_x (plot_x),
    .plot_y (plot_y), .plot_color (plot_color), .game_state (game_state)
  );

  always #20 CLOCK_50 = ~CLOCK_50;

  task automatic check_pixel(x_t ex, y_t ey, color_t ec, x_t ax, y_t ay, color_t ac);
    if (ex !== ax || ey !== ay || ec !== ac)
    begin
      errors++;
      $display("Error at %0t: pixel expected (%0d,%0d,%0d) got (%0d,%0d,%0d)",
               $time, ex, ey, ec, ax, ay, ac);
    end
  endtask

  task automatic check_state(game_state_t exp, game_state_t act);
    if (exp !== act)
    begin
      errors++;
      $display("Error at %0t: state expected %s got %s", $time, exp.name(), act.name());
    end
  endtask

  // START and CLEAR advance on the mirrored frame tick
  always @(posedge CLOCK_50 or negedge rst_n)
  begin
    if (!rst_n)
      tcnt <= 0;
    else if (tcnt == TICK_DIV - 1)
    begin
      tcnt <= 0;
      if (mstate == START)
      begin
        lfsr_step();
        if (btn_left || btn_right || btn_up || btn_down)
          mstate = CLEAR;
      end
      else if (mstate == CLEAR)
      begin
        clear_frame();
        play_frame(btn_left, btn_right, btn_up, btn_down, fire);  // inputs held until drawn
      end
      else if ((mstate == GAME_OVER || mstate == WIN) && restart)
        mstate = START;
    end
    else
      tcnt <= tcnt + 1;
  end

  // plot monitor and the only place buttons change during play
  always @(posedge CLOCK_50)
  begin
    logic [4:0] nb;
    if (rst_n && plot_valid && plot_ready)
    begin
      if (plot_x >= SCREEN_W || plot_y >= SCREEN_H)
      begin
        errors++;
        $display("Off-screen pixel presented at %0t", $time);
      end
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("Unexpected pixel at %0t with nothing left in the model", $time);
      end
      else
      begin
        head = exp_q.pop_front();
        check_pixel(head[17:10], head[9:3], head[2:0], plot_x, plot_y, plot_color);
        if (head[19:18] == 2'd1)
        begin
          nb = 5'($urandom);
          btn_left  <= nb[0];
          btn_right <= nb[1];
          btn_up    <= nb[2];
          btn_down  <= nb[3];
          fire      <= nb[4];
          play_frame(nb[0], nb[1], nb[2], nb[3], nb[4]);
        end
        else if (head[19:18] == 2'd2 && mstate == PLAY)
        begin
          check_state(PLAY, game_state);
          $display("clear round %0d: full black screen done, errors %0d", round_no, errors);
        end
      end
    end
    plot_ready <= ($urandom % 10) < 7;
  end

  always @(posedge CLOCK_50)
  begin
    cycles++;
    if (cycles >= LIMIT)
    begin
      $display("The run timed out after %0d cycles", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  initial
  begin
    logic [4:0] pb;
    void'($urandom(96));
    CLOCK_50 = 0;
    rst_n = 0;
    {btn_left, btn_right, btn_up, btn_down, fire, restart} = '0;
    plot_ready = 0;
    mstate = START;
    m_lfsr = LFSR_SEED;
    repeat (8) @(posedge CLOCK_50);
    rst_n <= 1;
    for (round_no = 0; round_no < ROUNDS; round_no++)
    begin
      repeat ($urandom % 1200) @(posedge CLOCK_50);
      game_done = 0;
      frames = 0;
      do pb = 5'($urandom); while (pb[3:1] == 0);
      btn_left  <= 1'b0;
      btn_right <= pb[1];
      btn_up    <= pb[2];
      btn_down  <= pb[3];
      fire      <= pb[4];
      while (!(game_done && exp_q.size() == 0))
        @(posedge CLOCK_50);
      @(negedge CLOCK_50);
      check_state(mstate, game_state);
      $display("game round %0d: %0d frames, ended in %s, errors %0d",
               round_no, frames, mstate.name(), errors);
      @(posedge CLOCK_50);
      restart <= 1'b1;
      while (mstate != START)
        @(posedge CLOCK_50);
      @(negedge CLOCK_50);
      check_state(START, game_state);
      $display("restart round %0d: back in START, errors %0d", round_no, errors);
      @(posedge CLOCK_50);
      {btn_left, btn_right, btn_up, btn_down, fire, restart} <= '0;
    end
    $display("%0d rounds, %0d errors", ROUNDS, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/shooter_top.sv */
`timescale 1ns/1ps
`default_nettype none

module shooter_top import game_pkg::*; #(
  parameter int TICK_DIV   = 64,
  parameter int FIFO_DEPTH = 16
) (
  input  logic        CLOCK_50,
  input  logic        rst_n,
  input  logic        btn_left,
  input  logic        btn_right,
  input  logic        btn_up,
  input  logic        btn_down,
  input  logic        fire,
  input  logic        restart,
  input  logic        plot_ready,
  output logic        plot_valid,
  output x_t          plot_x,
  output y_t          plot_y,
  output color_t      plot_color,
  output game_state_t game_state
);

  logic   req_valid, req_ready;  // box requests
  x_t     req_x, req_w;
  y_t     req_y, req_h;
  color_t req_color;
  logic   pix_valid, pix_ready;  // rasterized pixels
  x_t     pix_x;
  y_t     pix_y;
  color_t pix_color;
  logic   out_valid, out_ready;  // fifo head
  x_t     out_x;
  y_t     out_y;
  color_t out_color;

  game_ctrl #(
    .TICK_DIV (TICK_DIV)
  ) u_ctrl (
    .CLOCK_50   (CLOCK_50),
    .rst_n      (rst_n),
    .btn_left   (btn_left),
    .btn_right  (btn_right),
    .btn_up     (btn_up),
    .btn_down   (btn_down),
    .fire       (fire),
    .restart    (restart),
    .req_ready  (req_ready),
    .req_valid  (req_valid),
    .req_x      (req_x),
    .req_y      (req_y),
    .req_w      (req_w),
    .req_h      (req_h),
    .req_color  (req_color),
    .game_state (game_state)
  );

  box_raster u_raster (
    .CLOCK_50  (CLOCK_50),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_x     (req_x),
    .req_y     (req_y),
    .req_w     (req_w),
    .req_h     (req_h),
    .req_color (req_color),
    .pix_ready (pix_ready),
    .req_ready (req_ready),
    .pix_valid (pix_valid),
    .pix_x     (pix_x),
    .pix_y     (pix_y),
    .pix_color (pix_color)
  );

  plot_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .CLOCK_50  (CLOCK_50),
    .rst_n     (rst_n),
    .pix_valid (pix_valid),
    .pix_x     (pix_x),
    .pix_y     (pix_y),
    .pix_color (pix_color),
    .out_ready (out_ready),
    .pix_ready (pix_ready),
    .out_valid (out_valid),
    .out_x     (out_x),
    .out_y     (out_y),
    .out_color (out_color)
  );

  plot_clip u_clip (
    .CLOCK_50   (CLOCK_50),
    .rst_n      (rst_n),
    .out_valid  (out_valid),
    .out_x      (out_x),
    .out_y      (out_y),
    .out_color  (out_color),
    .plot_ready (plot_ready),
    .out_ready  (out_ready),
    .plot_valid (plot_valid),
    .plot_x     (plot_x),
    .plot_y     (plot_y),
    .plot_color (plot_color)
  );

endmodule

`default_nettype wire

/* rtl/plot_clip.sv */
`timescale 1ns/1ps
`default_nettype none

module plot_clip import game_pkg::*; (
  input  logic   CLOCK_50,
  input  logic   rst_n,
  input  logic   out_valid,
  input  x_t     out_x,
  input  y_t     out_y,
  input  color_t out_color,
  input  logic   plot_ready,
  output logic   out_ready,
  output logic   plot_valid,
  output x_t     plot_x,
  output y_t     plot_y,
  output color_t plot_color
);

  logic load;       // output stage free this cycle
  logic on_screen;

  assign load      = !plot_valid || plot_ready;
  assign out_ready = load;  // off-screen heads pop here too
  assign on_screen = (out_x < SCREEN_W) && (out_y < SCREEN_H);

  always_ff @(posedge CLOCK_50 or negedge rst_n)
  begin
    if (!rst_n)
      plot_valid <= 1'b0;
    else if (load)
      plot_valid <= out_valid && on_screen;
  end

  always_ff @(posedge CLOCK_50)
  begin
    if (load)
    begin
      plot_x     <= out_x;
      plot_y     <= out_y;
      plot_color <= out_color;
    end
  end

  a_on_screen: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
    plot_valid |-> (plot_x < SCREEN_W) && (plot_y < SCREEN_H));

  a_hold_stall: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
    plot_valid && !plot_ready |=> plot_valid && $stable({plot_x, plot_y, plot_color}));

endmodule

`default_nettype wire

/* rtl/plot_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module plot_fifo import game_pkg::*; #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic   CLOCK_50,
  input  logic   rst_n,
  input  logic   pix_valid,
  input  x_t     pix_x,
  input  y_t     pix_y,
  input  color_t pix_color,
  input  logic   out_ready,
  output logic   pix_ready,
  output logic   out_valid,
  output x_t     out_x,
  output y_t     out_y,
  output color_t out_color
);

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam logic [AW:0] FULL_CNT = (AW+1)'(FIFO_DEPTH);

  logic [17:0]   mem [FIFO_DEPTH];  // {x, y, colour}
  logic [AW-1:0] wr_ptr, rd_ptr;
  logic [AW:0]   count;             // occupancy
  logic          push, pop;

  assign pix_ready = (count != FULL_CNT);
  assign out_valid = (count != '0);
  assign push      = pix_valid && pix_ready;
  assign pop       = out_valid && out_ready;
  assign {out_x, out_y, out_color} = mem[rd_ptr];  // head visible right after push

  always_ff @(posedge CLOCK_50 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at the power-of-two depth
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge CLOCK_50)
  begin
    if (push)
      mem[wr_ptr] <= {pix_x, pix_y, pix_color};
  end

  // occupancy never passes the depth nor wraps below zero
  a_count_bound: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
    count <= FULL_CNT);

  // occupancy agrees with the pointer distance
  a_count_ptrs: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
    count[AW-1:0] == AW'(wr_ptr - rd_ptr));

endmodule

`default_nettype wire

/* rtl/box_raster.sv */
`timescale 1ns/1ps
`default_nettype none

module box_raster import game_pkg::*; (
  input  logic   CLOCK_50,
  input  logic   rst_n,
  input  logic   req_valid,
  input  x_t     req_x,
  input  y_t     req_y,
  input  x_t     req_w,
  input  y_t     req_h,
  input  color_t req_color,
  input  logic   pix_ready,
  output logic   req_ready,
  output logic   pix_valid,
  output x_t     pix_x,
  output y_t     pix_y,
  output color_t pix_color
);

  logic busy;       // box in progress
  x_t   box_x, box_w, col;
  y_t   box_y, box_h, row;

  assign req_ready = !busy;
  assign pix_valid = busy;
  assign pix_x     = box_x + col;  // wraps, clipper drops it
  assign pix_y     = box_y + row;

  always_ff @(posedge CLOCK_50 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy <= 1'b0;
      col  <= '0;
      row  <= '0;
    end
    else if (req_valid && req_ready)
    begin
      busy <= 1'b1;
      col  <= '0;
      row  <= '0;
    end
    else if (pix_valid && pix_ready)
    begin
      if (col == box_w - 8'd1)  // end of row
      begin
        col <= '0;
        if (row == box_h - 7'd1)
          busy <= 1'b0;  // last pixel gone
        else
          row <= row + 7'd1;
      end
      else
        col <= col + 8'd1;
    end
  end

  always_ff @(posedge CLOCK_50)
  begin
    if (req_valid && req_ready)
    begin
      box_x     <= req_x;
      box_y     <= req_y;
      box_w     <= req_w;
      box_h     <= req_h;
      pix_color <= req_color;
    end
  end

  a_accept_to_pix: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
    req_valid && req_ready |=> pix_valid && !req_ready);

  // ready only comes back after a pixel leaves
  a_ready_after_pix: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
    $rose(req_ready) |-> $past(pix_valid && pix_ready));

endmodule

`default_nettype wire

/* rtl/game_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module game_ctrl import game_pkg::*; #(
  parameter int TICK_DIV = 64
) (
  input  logic        CLOCK_50,
  input  logic        rst_n,
  input  logic        btn_left,
  input  logic        btn_right,
  input  logic        btn_up,
  input  logic        btn_down,
  input  logic        fire,
  input  logic        restart,
  input  logic        req_ready,
  output logic        req_valid,
  output x_t          req_x,
  output y_t          req_y,
  output x_t          req_w,
  output y_t          req_h,
  output color_t      req_color,
  output game_state_t game_state
);

  localparam int TW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [TW-1:0] tick_cnt;  // frame divider
  logic          tick;
  logic          frame_go;  // tick with previous frame drained
  logic [6:0]    lfsr;
  logic [6:0]    pending;   // one bit per box still to issue
  logic [6:0]    first_box; // lowest set pending bit only
  logic          end_drawn; // end screen already sent
  x_t            ship_x, enemy_x, bul_x;
  y_t            ship_y, enemy_y, bul_y;
  logic          bul_act;
  x_t            ers_ship_x, ers_enemy_x, ers_bul_x;  // positions to erase
  y_t            ers_ship_y, ers_enemy_y, ers_bul_y;
  x_t            nxt_ship_x, nxt_enemy_x, nxt_bul_x;
  y_t            nxt_ship_y, nxt_bul_y;
  logic          nxt_bul_act;
  y_t            spawn_y;
  logic          hit_lose, hit_win, draw_en;

  function automatic logic overlap(x_t ax, y_t ay, x_t aw, y_t ah,
                                   x_t bx, y_t by, x_t bw, y_t bh);
    return (9'(ax) < 9'(bx) + 9'(bw)) && (9'(bx) < 9'(ax) + 9'(aw)) &&
           (8'(ay) < 8'(by) + 8'(bh)) && (8'(by) < 8'(ay) + 8'(ah));
  endfunction

  assign tick      = (tick_cnt == TW'(TICK_DIV - 1));
  assign frame_go  = tick && (pending == '0);
  assign req_valid = |pending;
  assign first_box = pending & (~pending + 7'd1);
  assign spawn_y   = (lfsr <= SCREEN_H - ENEMY_H) ? lfsr : lfsr - 7'd32;  // keep on screen

  always_comb
  begin
    nxt_ship_x  = ship_x;
    nxt_ship_y  = ship_y;
    nxt_enemy_x = enemy_x - 8'd1;  // drifts left one column per frame
    nxt_bul_x   = bul_x;
    nxt_bul_y   = bul_y;
    nxt_bul_act = bul_act;
    if (btn_left && nxt_ship_x != '0)
      nxt_ship_x = nxt_ship_x - 8'd1;
    if (btn_right && nxt_ship_x < SCREEN_W - SHIP_W)
      nxt_ship_x = nxt_ship_x + 8'd1;
    if (btn_up && nxt_ship_y < SCREEN_H - SHIP_H)  // up means larger y
      nxt_ship_y = nxt_ship_y + 7'd1;
    if (btn_down && nxt_ship_y != '0)
      nxt_ship_y = nxt_ship_y - 7'd1;
    if (bul_act)
    begin
      nxt_bul_x = bul_x + 8'd1;
      if (nxt_bul_x >= SCREEN_W - BULLET_W)
        nxt_bul_act = 1'b0;  // left the right edge
    end
    if (fire && !nxt_bul_act)
    begin
      nxt_bul_x   = nxt_ship_x + BULLET_DX;
      nxt_bul_y   = nxt_ship_y + BULLET_DY;
      nxt_bul_act = 1'b1;
    end
    hit_lose = overlap(nxt_ship_x, nxt_ship_y, SHIP_W, SHIP_H,
                       nxt_enemy_x, enemy_y, ENEMY_W, ENEMY_H) || (nxt_enemy_x == '0);
    hit_win  = nxt_bul_act && overlap(nxt_bul_x, nxt_bul_y, BULLET_W, BULLET_H,
                                      nxt_enemy_x, enemy_y, ENEMY_W, ENEMY_H);
    draw_en  = !hit_lose && !hit_win;
  end

  // lowest pending bit picks the box
  always_comb
  begin
    req_x     = '0;
    req_y     = '0;
    req_w     = SCREEN_W;  // full screen by default
    req_h     = SCREEN_H;
    req_color = (game_state == WIN) ? COL_WIN :
                (game_state == GAME_OVER) ? COL_LOSE : COL_BLACK;
    if (first_box[0])
      req_x = '0;  // full-screen fill from the defaults
    else if (first_box[1] || first_box[4])
    begin
      req_x     = first_box[1] ? ers_ship_x : ship_x;
      req_y     = first_box[1] ? ers_ship_y : ship_y;
      req_w     = SHIP_W;
      req_h     = SHIP_H;
      req_color = first_box[1] ? COL_BLACK : COL_SHIP;
    end
    else if (first_box[2] || first_box[5])
    begin
      req_x     = first_box[2] ? ers_enemy_x : enemy_x;
      req_y     = first_box[2] ? ers_enemy_y : enemy_y;
      req_w     = ENEMY_W;
      req_h     = ENEMY_H;
      req_color = first_box[2] ? COL_BLACK : COL_ENEMY;
    end
    else if (first_box[3] || first_box[6])
    begin
      req_x     = first_box[3] ? ers_bul_x : bul_x;
      req_y     = first_box[3] ? ers_bul_y : bul_y;
      req_w     = BULLET_W;
      req_h     = BULLET_H;
      req_color = first_box[3] ? COL_BLACK : COL_BULLET;
    end
  end

  always_ff @(posedge CLOCK_50 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tick_cnt   <= '0;
      lfsr       <= LFSR_SEED;
      pending    <= '0;
      end_drawn  <= 1'b0;
      game_state <= START;
      ship_x     <= '0;
      ship_y     <= '0;
      enemy_x    <= ENEMY_START_X;
      enemy_y    <= '0;
      bul_x      <= '0;
      bul_y      <= '0;
      bul_act    <= 1'b0;
    end
    else
    begin
      tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
      if (tick && game_state == START)
        lfsr <= {lfsr[5:0], lfsr[4] ^ lfsr[1]};
      if (req_valid && req_ready)
        pending <= pending & (pending - 7'd1);  // drop lowest set bit
      if (frame_go)
      begin
        case (game_state)
          START:
            if (btn_left || btn_right || btn_up || btn_down)
              game_state <= CLEAR;
          CLEAR:
          begin
            ship_x     <= '0;
            ship_y     <= '0;
            enemy_x    <= ENEMY_START_X;
            enemy_y    <= spawn_y;
            bul_act    <= 1'b0;
            pending    <= 7'b0000001;  // black screen
            game_state <= PLAY;
          end
          PLAY:
          begin
            ship_x  <= nxt_ship_x;
            ship_y  <= nxt_ship_y;
            enemy_x <= nxt_enemy_x;
            bul_x   <= nxt_bul_x;
            bul_y   <= nxt_bul_y;
            bul_act <= nxt_bul_act;
            pending <= {draw_en && nxt_bul_act, draw_en, draw_en, bul_act, 2'b11, 1'b0};
            if (hit_lose)
              game_state <= GAME_OVER;
            else if (hit_win)
              game_state <= WIN;
          end
          GAME_OVER, WIN:
            if (!end_drawn)
            begin
              pending   <= 7'b0000001;  // lose or win fill
              end_drawn <= 1'b1;
            end
            else if (restart)
            begin
              end_drawn  <= 1'b0;
              ship_x     <= '0;
              ship_y     <= '0;
              enemy_x    <= ENEMY_START_X;
              bul_act    <= 1'b0;
              game_state <= START;
            end
          default:
            game_state <= START;
        endcase
      end
    end
  end

  always_ff @(posedge CLOCK_50)
  begin
    if (frame_go)
    begin
      ers_ship_x  <= ship_x;
      ers_ship_y  <= ship_y;
      ers_enemy_x <= enemy_x;
      ers_enemy_y <= enemy_y;
      ers_bul_x   <= bul_x;
      ers_bul_y   <= bul_y;
    end
  end

  // a frame only opens on a tick
  a_req_needs_tick: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
    !req_valid && !tick |=> !req_valid);

  a_req_stable: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
    req_valid && !req_ready |=> req_valid && $stable({req_x, req_y, req_w, req_h, req_color}));

endmodule

`default_nettype wire

/* rtl/game_pkg.sv */
`default_nettype none

package game_pkg;

  typedef logic [7:0] x_t;    // column, also box width
  typedef logic [6:0] y_t;    // row, also box height
  typedef logic [2:0] color_t;  // 3-bit rgb

  typedef enum logic [2:0] {
    START     = 3'd0,
    CLEAR     = 3'd1,
    PLAY      = 3'd2,
    GAME_OVER = 3'd3,
    WIN       = 3'd4
  } game_state_t;

  localparam x_t SCREEN_W = 8'd160;
  localparam y_t SCREEN_H = 7'd120;

  localparam x_t SHIP_W   = 8'd16;
  localparam y_t SHIP_H   = 7'd10;
  localparam x_t ENEMY_W  = 8'd16;
  localparam y_t ENEMY_H  = 7'd10;
  localparam x_t BULLET_W = 8'd4;
  localparam y_t BULLET_H = 7'd1;

  localparam x_t ENEMY_START_X = 8'd140;  // spawn column, right edge
  localparam x_t BULLET_DX     = 8'd16;   // nose of the ship
  localparam y_t BULLET_DY     = 7'd4;

  localparam color_t COL_BLACK  = 3'b000;
  localparam color_t COL_SHIP   = 3'b010;
  localparam color_t COL_ENEMY  = 3'b100;
  localparam color_t COL_BULLET = 3'b110;
  localparam color_t COL_LOSE   = 3'b101;
  localparam color_t COL_WIN    = 3'b011;

  localparam logic [6:0] LFSR_SEED = 7'h3f;  // height generator reset value

endpackage

`default_nettype wire
